//--- build.f
+incdir+.
convPkg.sv
convCtrlIf.sv
processingElement.sv
convUnit.sv
convRegs.sv
convTop.sv
convTop_checker.sv
convScoreboard.sv
convTb.sv

//--- convCtrlIf.sv
`include "conv_settings.svh"

interface convCtrlIf
	import convPkg::*;
();

	window_t window; // image pixels, held by the host registers
	window_t filter; // weights
	logic    start;  // one cycle pulse
	logic    busy;   // high for the whole run
	logic    done;   // one cycle pulse, result valid with it
	acc_t    result;

	// host register side
	modport regs (
		output window,
		output filter,
		output start,
		input  busy,
		input  done,
		input  result
	);

	// convolution side, reads operands live
	modport unit (
		input  window,
		input  filter,
		input  start,
		output busy,
		output done,
		output result
	);

endinterface

//--- convPkg.sv
`include "conv_settings.svh"

package convPkg;

	// one pixel or one weight, signed fixed point
	typedef logic signed [`DATA_WIDTH-1:0] pixel_t;

	// accumulator and result word
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axiResp_t;

	// 3x3 block in row-major order, element 0 is top left
	// same shape for the image window and the filter
	typedef pixel_t [`FILTER_ELEMS-1:0] window_t;

endpackage

//--- convRegs.sv
`include "conv_settings.svh"

module convRegs
	import convPkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
	input  logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output axiResp_t                     bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`AXI_DATA_WIDTH-1:0]   rdata,
	output axiResp_t                     rresp,
	output logic                         rvalid,
	input  logic                         rready,
	convCtrlIf.regs                      ctrl
);

	window_t filterReg; // weights
	window_t windowReg; // pixels
	logic    doneFlag;  // sticky until next start
	acc_t    resultReg; // last completed run
	logic    wrFire;
	logic    rdFire;
	logic    wrWeight;
	logic    wrPixel;
	logic    wrMapped;
	logic    rdWeight;
	logic    rdPixel;
	logic [3:0] wrIdx;
	logic [3:0] rdIdx;
	pixel_t  rdPix;
	logic    rdOk;
	logic [`AXI_DATA_WIDTH-1:0] rdNext;

	// word aligned hit inside a nine word bank
	function automatic logic inBank(input logic [`AXI_ADDR_WIDTH-1:0] addr,
			input logic [`AXI_ADDR_WIDTH-1:0] base);
		logic [`AXI_ADDR_WIDTH-1:0] offs;
		offs = addr - base;
		return (addr >= base) && (offs < `AXI_ADDR_WIDTH'(4 * `FILTER_ELEMS))
			&& (addr[1:0] == 2'b00);
	endfunction

	function automatic logic [3:0] bankIndex(input logic [`AXI_ADDR_WIDTH-1:0] addr,
			input logic [`AXI_ADDR_WIDTH-1:0] base);
		logic [`AXI_ADDR_WIDTH-1:0] offs;
		offs = addr - base;
		return offs[5:2]; // word index
	endfunction

	// byte lanes of a pixel word, upper strobes have no storage
	function automatic pixel_t mergeBytes(input pixel_t old,
			input logic [`AXI_DATA_WIDTH-1:0] data,
			input logic [`AXI_DATA_WIDTH/8-1:0] strb);
		pixel_t merged;
		merged = old;
		for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
			if (strb[b])
				merged[b*8 +: 8] = data[b*8 +: 8];
		end
		return merged;
	endfunction

	// write decode
	assign wrFire   = awready && wready && awvalid && wvalid;
	assign wrWeight = inBank(awaddr, `REG_WEIGHT_BASE);
	assign wrPixel  = inBank(awaddr, `REG_PIXEL_BASE);
	assign wrIdx    = wrWeight ? bankIndex(awaddr, `REG_WEIGHT_BASE)
		: bankIndex(awaddr, `REG_PIXEL_BASE);
	assign wrMapped = wrWeight || wrPixel || (awaddr == `REG_CTRL)
		|| (awaddr == `REG_STATUS) || (awaddr == `REG_RESULT); // last two read only

	// start pulse in the accept cycle, dropped while a run is going
	assign ctrl.start = wrFire && (awaddr == `REG_CTRL) && wstrb[0] && wdata[0]
		&& !ctrl.busy;

	// operand storage, frozen during a run
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			filterReg <= '0;
			windowReg <= '0;
		end else if (wrFire && !ctrl.busy) begin
			if (wrWeight)
				filterReg[wrIdx] <= mergeBytes(filterReg[wrIdx], wdata, wstrb);
			if (wrPixel)
				windowReg[wrIdx] <= mergeBytes(windowReg[wrIdx], wdata, wstrb);
		end
	end

	assign ctrl.filter = filterReg;
	assign ctrl.window = windowReg;

	// status and result
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			doneFlag  <= 1'b0;
			resultReg <= '0;
		end else begin
			if (ctrl.start)
				doneFlag <= 1'b0;
			else if (ctrl.done)
				doneFlag <= 1'b1;
			if (ctrl.done)
				resultReg <= ctrl.result;
		end
	end

	// write channel: aw and w accepted together, one response outstanding
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= OKAY;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid; // one cycle ready
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wrFire) begin
				bvalid <= 1'b1;
				bresp  <= wrMapped ? OKAY : SLVERR;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// read decode
	assign rdWeight = inBank(araddr, `REG_WEIGHT_BASE);
	assign rdPixel  = inBank(araddr, `REG_PIXEL_BASE);
	assign rdIdx    = rdWeight ? bankIndex(araddr, `REG_WEIGHT_BASE)
		: bankIndex(araddr, `REG_PIXEL_BASE);

	always_comb begin
		rdPix  = rdWeight ? filterReg[rdIdx] : windowReg[rdIdx];
		rdOk   = 1'b1;
		rdNext = '0; // ctrl reads as zero
		if (rdWeight || rdPixel)
			rdNext = {{(`AXI_DATA_WIDTH - `DATA_WIDTH){rdPix[`DATA_WIDTH-1]}}, rdPix};
		else if (araddr == `REG_STATUS)
			rdNext = {{(`AXI_DATA_WIDTH - 2){1'b0}}, doneFlag, ctrl.busy};
		else if (araddr == `REG_RESULT)
			rdNext = resultReg;
		else if (araddr != `REG_CTRL)
			rdOk = 1'b0; // unmapped
	end

	// read channel, data captured at accept and held under back-pressure
	assign arready = !rvalid;
	assign rdFire  = arvalid && arready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= OKAY;
		end else if (rdFire) begin
			rvalid <= 1'b1;
			rdata  <= rdNext;
			rresp  <= rdOk ? OKAY : SLVERR;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

//--- convScoreboard.sv
module convScoreboard (
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  bresp,
	input  logic        bvalid,
	input  logic        bready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rvalid,
	input  logic        rready,
	input  logic        expPush,     // one entry per issued transaction
	input  logic        expIsRead,
	input  logic [7:0]  expAddr,
	input  logic [31:0] expData,
	input  logic [31:0] expMask,     // zero bits are don't care
	input  logic [1:0]  expResp,
	input  logic        testEnd,
	input  int          testId,
	input  logic        testExtFail, // timeout seen by the driver
	output int          passCount,
	output int          failCount
);

	typedef struct packed {
		logic        isRead;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [31:0] mask;
		logic [1:0]  resp;
	} expEntry_t;

	expEntry_t expQ[$]; // issue order, one transaction at a time
	expEntry_t head;
	int        mismatches;
	logic      readResp;

	always @(posedge clk) begin
		readResp = rvalid && rready;
		if (reset) begin
			passCount  = 0;
			failCount  = 0;
			mismatches = 0;
			expQ.delete();
		end else begin
			if (expPush)
				expQ.push_back('{expIsRead, expAddr, expData, expMask, expResp});
			if ((bvalid && bready) || readResp) begin
				if (expQ.size() == 0) begin
					$display("test %0d: response arrived with nothing outstanding", testId);
					mismatches++;
				end else begin
					head = expQ.pop_front();
					if (head.isRead != readResp) begin
						$display("test %0d: response came back on the wrong channel", testId);
						mismatches++;
					end else if (readResp) begin
						if ((rdata & head.mask) != (head.data & head.mask)) begin
							$display("FAIL rdata @0x%02h: got 0x%08h, expected 0x%08h",
								head.addr, rdata, head.data);
							mismatches++;
						end
						if (rresp != head.resp) begin
							$display("FAIL rresp @0x%02h: got 0x%01h, expected 0x%01h",
								head.addr, rresp, head.resp);
							mismatches++;
						end
					end else if (bresp != head.resp) begin
						$display("FAIL bresp @0x%02h: got 0x%01h, expected 0x%01h",
							head.addr, bresp, head.resp);
						mismatches++;
					end
				end
			end
			if (testEnd) begin
				if (expQ.size() != 0) begin // requests without a response
					$display("test %0d: %0d responses never arrived", testId, expQ.size());
					mismatches++;
					expQ.delete();
				end
				if (mismatches == 0 && !testExtFail) begin
					passCount++;
					$display("test %0d ok", testId);
				end else begin
					failCount++;
					$display("test %0d failed, %0d mismatches", testId, mismatches);
				end
				mismatches = 0;
			end
		end
	end

endmodule

//--- convTb.sv
`include "conv_settings.svh"

module convTb
	import convPkg::*;
();

	localparam int NROWS      = 12;
	localparam int NORMAL     = 0;
	localparam int BUSY_WRITE = 1;
	localparam int BAD_ADDR   = 2;

	logic clk;
	logic reset;
	logic [`AXI_ADDR_WIDTH-1:0] awaddr, araddr;
	logic [`AXI_DATA_WIDTH-1:0] wdata, rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	logic expPush, expIsRead, testEnd, testExtFail, hadError;
	logic [7:0] expAddr;
	logic [31:0] expData, expMask, got;
	logic [1:0] expResp;
	int testId, passCount, failCount, acceptCycle, startCycle, seed;
	int cycle = 0;
	pixel_t pixTbl [NROWS][9];
	pixel_t wtTbl [NROWS][9];
	int modeTbl [NROWS];

	convTop dut_i (.*);

	convScoreboard sb_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// run length bound, 400 cycles per test plus margin
	initial begin
		#((NROWS + 1) * 400 * 20 + 4000);
		$display("watchdog: run did not finish in time");
		$display("Regression failed");
		$finish;
	end

	task automatic step(); // inputs change 2 units after the edge
		@(posedge clk);
		#2;
	endtask

	task automatic pushExpect(input logic isRead, input logic [7:0] addr,
			input logic [31:0] data, input logic [31:0] mask, input logic [1:0] resp);
		expIsRead = isRead;
		expAddr   = addr;
		expData   = data;
		expMask   = mask;
		expResp   = resp;
		expPush   = 1'b1;
		step();
		expPush   = 1'b0;
	endtask

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
			input logic [1:0] resp, input int stall = 0);
		int waitCnt = 0;
		pushExpect(1'b0, addr, '0, '0, resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = (stall == 0);
		while (!(awready && wready) && waitCnt < 20) begin
			step();
			waitCnt++;
		end
		step(); // accepting edge
		acceptCycle = cycle;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid && waitCnt < 40) begin
			step();
			waitCnt++;
		end
		if (waitCnt >= 20) begin
			$display("test %0d: write to 0x%02h got no accept or response", testId, addr);
			hadError = 1'b1;
		end
		repeat (stall) step(); // back-pressure, response must hold
		bready = 1'b1;
		step(); // response taken here
	endtask

	task automatic axiRead(input logic [7:0] addr, input logic [31:0] data,
			input logic [31:0] mask, input logic [1:0] resp, input int stall,
			output logic [31:0] value);
		int waitCnt = 0;
		pushExpect(1'b1, addr, data, mask, resp);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = (stall == 0);
		while (!arready && waitCnt < 20) begin
			step();
			waitCnt++;
		end
		step();
		arvalid = 1'b0;
		while (!rvalid && waitCnt < 40) begin
			step();
			waitCnt++;
		end
		if (!rvalid) begin
			$display("test %0d: read of 0x%02h got no response", testId, addr);
			hadError = 1'b1;
		end
		repeat (stall) step(); // back-pressure, response must hold
		rready = 1'b1;
		value  = rdata;
		step();
	endtask

	task automatic endTest();
		testExtFail = hadError;
		testEnd     = 1'b1;
		step();
		testEnd     = 1'b0;
		hadError    = 1'b0;
	endtask

	// wrapped sum of the nine signed products
	function automatic logic [31:0] dotProduct(input int r);
		int acc = 0;
		for (int i = 0; i < 9; i++)
			acc += int'(pixTbl[r][i]) * int'(wtTbl[r][i]); // int wraps at 32 bits
		return acc;
	endfunction

	task automatic buildTable();
		seed = 32'hd4d8;
		for (int r = 0; r < NROWS; r++) begin
			modeTbl[r] = NORMAL;
			for (int i = 0; i < 9; i++) begin
				pixTbl[r][i] = pixel_t'($random(seed));
				wtTbl[r][i]  = pixel_t'($random(seed));
			end
		end
		for (int i = 0; i < 9; i++) begin
			pixTbl[0][i] = '0; // all zeros
			wtTbl[0][i]  = '0;
			pixTbl[1][i] = pixel_t'(i + 1);
			wtTbl[1][i]  = (i == 4) ? pixel_t'(1) : pixel_t'(0); // identity filter
			pixTbl[2][i] = pixel_t'(-100 * (i + 1));
			wtTbl[2][i]  = pixel_t'((i % 2 == 0) ? -7 : 3);
			pixTbl[3][i] = 16'h8000; // full-scale, sum wraps
			wtTbl[3][i]  = 16'h8000;
			pixTbl[4][i] = 16'h8000;
			wtTbl[4][i]  = 16'h7fff;
		end
		modeTbl[4] = BUSY_WRITE;
		modeTbl[5] = BAD_ADDR;
		modeTbl[8] = BUSY_WRITE;
	endtask

	task automatic runRow(input int r);
		testId = r + 1;
		for (int i = 0; i < 9; i++) begin
			axiWrite(8'(`REG_WEIGHT_BASE + 4 * i), 32'(wtTbl[r][i]), OKAY);
			axiWrite(8'(`REG_PIXEL_BASE + 4 * i), 32'(pixTbl[r][i]), OKAY);
		end
		if (modeTbl[r] == BAD_ADDR) begin
			axiRead(8'h0c, '0, '0, SLVERR, 0, got);
			axiWrite(8'h34, 32'h1234, SLVERR, 3); // just past the weight bank, response held
			axiRead(8'h34, '0, '0, SLVERR, 0, got);
			axiWrite(8'h12, 32'h7777, SLVERR); // misaligned
		end
		for (int i = 0; i < 9; i++) begin // sign-extended readback
			axiRead(8'(`REG_WEIGHT_BASE + 4 * i), 32'(wtTbl[r][i]), '1, OKAY, 0, got);
			axiRead(8'(`REG_PIXEL_BASE + 4 * i), 32'(pixTbl[r][i]), '1, OKAY, 0, got);
		end
		axiWrite(`REG_CTRL, 32'h1, OKAY);
		startCycle = acceptCycle;
		if (modeTbl[r] == BUSY_WRITE) begin
			axiWrite(`REG_WEIGHT_BASE, 32'(~wtTbl[r][0]), OKAY); // ignored while busy
			axiWrite(`REG_CTRL, 32'h1, OKAY); // second start
		end
		got = '0;
		while (!got[1] && (cycle - startCycle) <= 16) // 12 cycles plus a poll in flight
			axiRead(`REG_STATUS, '0, '0, OKAY, 0, got);
		if (!got[1]) begin
			$display("test %0d: doneFlag not set within 12 cycles of start", testId);
			hadError = 1'b1;
		end
		axiRead(`REG_STATUS, 32'h2, '1, OKAY, 0, got);
		axiRead(`REG_RESULT, dotProduct(r), '1, OKAY, 4, got);
		if (modeTbl[r] == BUSY_WRITE)
			axiRead(`REG_WEIGHT_BASE, 32'(wtTbl[r][0]), '1, OKAY, 0, got);
		endTest();
	endtask

	initial begin
		{reset, awvalid, wvalid, arvalid, expPush, testEnd, testExtFail, hadError} = 8'hff;
		{awvalid, wvalid, arvalid, expPush, testEnd, testExtFail, hadError} = '0;
		{awaddr, araddr, wdata, expAddr, expData, expMask, expResp, testId} = '0;
		wstrb  = 4'hf;
		bready = 1'b1;
		rready = 1'b1;
		buildTable();
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		step();
		axiRead(`REG_STATUS, '0, '1, OKAY, 0, got); // reset values
		axiRead(`REG_RESULT, '0, '1, OKAY, 0, got);
		for (int i = 0; i < 9; i++) begin
			axiRead(8'(`REG_WEIGHT_BASE + 4 * i), '0, '1, OKAY, 0, got);
			axiRead(8'(`REG_PIXEL_BASE + 4 * i), '0, '1, OKAY, 0, got);
		end
		endTest();
		for (int r = 0; r < NROWS; r++)
			runRow(r);
		step();
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			passCount, failCount, dut_i.chk_i.assertFails);
		if (failCount == 0 && passCount == NROWS + 1 && dut_i.chk_i.assertFails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- convTop.sv
`include "conv_settings.svh"

module convTop (
	input  logic                         clk,
	input  logic                         reset,
	// write address and data
	input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
	input  logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	// write response
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	// read
	input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`AXI_DATA_WIDTH-1:0]   rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready
);

	convCtrlIf ctrlIf (); // registers to sequencer

	convRegs regs_i (
		.clk     (clk),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.ctrl    (ctrlIf.regs)
	);

	convUnit unit_i (
		.clk   (clk),
		.reset (reset),
		.ctrl  (ctrlIf.unit)
	);

endmodule

//--- convTop_checker.sv
`include "conv_settings.svh"

module convTop_checker (
	input logic                       clk,
	input logic                       reset,
	input logic                       bvalid,
	input logic                       bready,
	input logic [1:0]                 bresp,
	input logic                       rvalid,
	input logic                       rready,
	input logic [`AXI_DATA_WIDTH-1:0] rdata,
	input logic [1:0]                 rresp,
	input logic                       start,
	input logic                       busy,
	input logic                       done
);

	int assertFails = 0; // read by the testbench at the end
	logic [10:0] startAge; // bit k set k+1 cycles after a start

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			startAge <= '0;
		else
			startAge <= {startAge[9:0], start};
	end

	// read response held until taken
	rHold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("read response changed or dropped before rready");
			assertFails++;
		end

	bHold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("write response changed or dropped before bready");
			assertFails++;
		end

	doneInRun: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else begin
			$error("done pulsed outside a run");
			assertFails++;
		end

	// busy over cycles 1..11 after start, done in cycle 11
	// a start slipping through mid-run would restart the count
	runTiming: assert property (@(posedge clk) disable iff (reset)
		(done == startAge[10]) && (busy == (|startAge)))
		else begin
			$error("busy or done out of step with the last start");
			assertFails++;
		end

endmodule

bind convTop convTop_checker chk_i (
	.clk    (clk),
	.reset  (reset),
	.bvalid (bvalid),
	.bready (bready),
	.bresp  (bresp),
	.rvalid (rvalid),
	.rready (rready),
	.rdata  (rdata),
	.rresp  (rresp),
	.start  (ctrlIf.start),
	.busy   (ctrlIf.busy),
	.done   (ctrlIf.done)
);

//--- convUnit.sv
`include "conv_settings.svh"

module convUnit
	import convPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	convCtrlIf.unit ctrl
);

	localparam int unsigned LAST_IDX = `FILTER_ELEMS - 1;

	logic [3:0] idx;       // element counter, FILTER_ELEMS means finished
	logic       feeding;   // a pair goes to the PE this cycle
	logic       lastFeed;  // final pair of the window
	pixel_t     selPixel;
	pixel_t     selWeight;
	logic [1:0] validPipe; // tracks the last pair through multiply and add
	logic       busyReg;
	acc_t       peResult;

	assign feeding  = (idx < 4'(`FILTER_ELEMS));
	assign lastFeed = feeding && (idx == 4'(LAST_IDX));

	// element counter
	// start restarts at 0, pairs go out in cycles 1..9
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			idx <= 4'(`FILTER_ELEMS); // idle
		else if (ctrl.start)
			idx <= '0;
		else if (feeding)
			idx <= idx + 4'd1;
	end

	// pair select, row-major
	always_comb begin
		selPixel  = '0; // zeros once the window is done
		selWeight = '0;
		if (feeding) begin
			selPixel  = ctrl.window[idx];
			selWeight = ctrl.filter[idx];
		end
	end

	processingElement pe_i (
		.clk    (clk),
		.reset  (reset),
		.clear  (ctrl.start), // fresh accumulator each run
		.floatA (selPixel),
		.floatB (selWeight),
		.enable (feeding),
		.result (peResult)
	);

	// last pair: fed cycle 9, product cycle 10, sum visible cycle 11
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[0], lastFeed};
	end

	// busy from cycle 1 through the done cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			busyReg <= 1'b0;
		else if (ctrl.start)
			busyReg <= 1'b1;
		else if (validPipe[1])
			busyReg <= 1'b0; // falls the cycle after done
	end

	assign ctrl.busy   = busyReg;
	assign ctrl.done   = validPipe[1];
	assign ctrl.result = peResult;

endmodule

//--- conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// pixel and weight width
`define DATA_WIDTH      16
`define FILTER_SIZE     3 // side of the square filter, depth fixed at 1
`define FILTER_ELEMS    (`FILTER_SIZE * `FILTER_SIZE)
`define ACC_WIDTH       32 // wrapping two's complement sum

// host bus shape
`define AXI_ADDR_WIDTH  8
`define AXI_DATA_WIDTH  32

// register map, byte offsets
`define REG_CTRL        8'h00 // bit 0 start
`define REG_STATUS      8'h04 // bit 0 busy, bit 1 doneFlag
`define REG_RESULT      8'h08
`define REG_WEIGHT_BASE 8'h10 // nine words, row-major
`define REG_PIXEL_BASE  8'h40 // nine words, row-major

`endif

//--- processingElement.sv
module processingElement
	import convPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   clear,  // zero accumulator and pending product
	input  pixel_t floatA, // pixel
	input  pixel_t floatB, // weight
	input  logic   enable, // operands valid this cycle
	output acc_t   result
);

	acc_t product;      // registered product
	logic productValid;
	acc_t accum;        // running sum

	// multiply stage
	// operands widened first so the product keeps its sign
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			product <= '0;
		else if (clear)
			product <= '0;
		else
			product <= acc_t'(floatA) * acc_t'(floatB);
	end

	// accumulate stage, one cycle behind the product
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			productValid <= 1'b0;
			accum        <= '0;
		end else if (clear) begin
			productValid <= 1'b0; // drop anything in flight
			accum        <= '0;
		end else begin
			productValid <= enable;
			if (productValid)
				accum <= accum + product; // wraps on overflow
		end
	end

	assign result = accum;

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the convolution testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module convTb -o simConv
./obj_dir/simConv +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
	exit 1
fi
grep -q "Regression passed" sim.log
